// File: Makefile
# Verilator build and run of the 6502 core testbench

SIM := obj_dir/Vcpu6502_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' sim.log || (echo "Simulation ended without a result"; exit 1)

# Rebuilt only when a source or the file list changes
$(SIM): cpu6502_top.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f cpu6502_top.f --top-module cpu6502_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: bench/cpu6502_props.sv
// ------------------------------------------------
// 6502 core bus and status properties
// ------------------------------------------------

`include "cpu6502_config.svh"

module cpu6502_props (
  input logic         clk,
  input logic         resetn,
  input logic [15:0]  address,
  input logic         wr_enable,
  input logic [7:0]   status
);

  timeunit 1ns;
  timeprecision 100ps;

  import cpu6502_pkg::*;

  // Single-cycle writes only
  single_write: assert property (@(posedge clk) disable iff (!resetn) wr_enable |=> !wr_enable)
    else $error("wr_enable high in two consecutive cycles");

  // Vector LSB on the bus right after release
  vector_first: assert property (@(posedge clk) $rose(resetn) |-> address == `CPU_RESET_LSB)
    else $error("address is not the reset vector LSB after reset release");

  unused_bit: assert property (@(posedge clk) disable iff (!resetn) status[FLAG_UNUSED])
    else $error("status bit 5 dropped to zero");

endmodule

bind cpu6502_top cpu6502_props props_inst (
  .clk, .resetn, .address, .wr_enable, .status
);

// File: bench/cpu6502_tb.sv
// ------------------------------------------------
// 6502 core testbench
// Memory model, case table, store and jump loop checks
// ------------------------------------------------

`include "cpu6502_config.svh"

module cpu6502_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cpu6502_pkg::*;

  typedef struct {
    string       name;
    opcode_t     op;          // Instruction under test on 0201
    logic [7:0]  a;           // Loaded first from 0200
    logic [7:0]  b;           // Held at 0201
    logic        cin;         // ADC carry set by an ASL prelude
    logic [7:0]  exp_result;  // Byte stored to 0300
    logic [7:0]  exp_status;
    logic [7:0]  exp_mem;     // 0201 after the run
  } test_case_t;

  logic         clk;
  logic         resetn;
  logic [7:0]   rd_data;
  logic [15:0]  address;
  logic [7:0]   wr_data;
  logic         wr_enable;
  logic [7:0]   status;

  // Program load port into memory
  logic         load_en;
  logic [15:0]  load_addr;
  logic [7:0]   load_data;

  logic [7:0]   mem [0:65535];
  test_case_t   cases [$];
  int           seed = 52055;

  cpu6502_top cpu6502_top_inst (
    .clk, .resetn, .rd_data, .address, .wr_data, .wr_enable, .status
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign rd_data = mem[address];  // Async read of registered address

  always @(posedge clk) begin
    if (load_en)
      mem[load_addr] <= load_data;
    else if (wr_enable)
      mem[address] <= wr_data;      // Core write at end of cycle
  end

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic logic [7:0] set_nz(input logic [7:0] st, input logic [7:0] value);
    logic [7:0] r;
    r            = st;
    r[FLAG_NEG]  = value[7];
    r[FLAG_ZERO] = (value == 8'h00);
    return r;
  endfunction

  function automatic void predict(input opcode_t op, input logic [7:0] a, input logic [7:0] b,
                                  input logic cin, output logic [7:0] res,
                                  output logic [7:0] st, output logic [7:0] m201);
    int sum;
    int ssum;
    st   = set_nz(8'h20, a);  // After LDA a
    res  = a;
    m201 = b;
    if (cin) begin
      st             = set_nz(st, 8'h00);  // ASL of 80 gives 00
      st[FLAG_CARRY] = 1'b1;
    end
    case (op)
      LDA_ABS: begin
        res = b;
        st  = set_nz(st, b);
      end
      ADC_ABS: begin
        sum            = int'(a) + int'(b) + int'(cin);
        ssum           = int'($signed(a)) + int'($signed(b)) + int'(cin);
        res            = sum[7:0];
        st             = set_nz(st, res);
        st[FLAG_CARRY] = (sum > 255);
        st[FLAG_OVF]   = (ssum > 127) || (ssum < -128);  // Outside signed byte range
      end
      AND_ABS: begin
        res = a & b;
        st  = set_nz(st, res);
      end
      ASL_ABS: begin
        m201           = b << 1;  // Memory shifted while A stays
        st             = set_nz(st, m201);
        st[FLAG_CARRY] = b[7];
      end
      default: ;
    endcase
  endfunction

  // ------------------------------------------------
  // Reporting
  // ------------------------------------------------
  task automatic report_mismatch(input string name, input string what,
                                 input logic [15:0] expected, input logic [15:0] actual);
    $display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
    $display(">>> FAIL");
    $fatal(1, "Value mismatch");
  endtask

  task automatic report_error(input string name, input string msg);
    $display("Error in case %s: %s", name, msg);
    $display(">>> FAIL");
    $fatal(1, "Check failed");
  endtask

  // ------------------------------------------------
  // Table and program setup
  // ------------------------------------------------
  task automatic add_case(input string name, input opcode_t op, input logic [7:0] a,
                          input logic [7:0] b, input logic cin, input logic [7:0] exp_result,
                          input logic [7:0] exp_status, input logic [7:0] exp_mem);
    test_case_t tc;
    tc.name       = name;
    tc.op         = op;
    tc.a          = a;
    tc.b          = b;
    tc.cin        = cin;
    tc.exp_result = exp_result;
    tc.exp_status = exp_status;
    tc.exp_mem    = exp_mem;
    cases.push_back(tc);
  endtask

  task automatic add_random_cases(input int count);
    logic [31:0] r;
    opcode_t     op;
    logic        cin;
    logic [7:0]  res, st, m201;
    for (int k = 0; k < count; k++) begin
      r = $random(seed);
      case (k % 4)
        0:       op = ADC_ABS;
        1:       op = AND_ABS;
        2:       op = ASL_ABS;
        default: op = LDA_ABS;
      endcase
      cin = (op == ADC_ABS) && r[16];
      predict(op, r[7:0], r[15:8], cin, res, st, m201);
      add_case($sformatf("random_%0d", k), op, r[7:0], r[15:8], cin, res, st, m201);
    end
  endtask

  // Called 1 ns after a rising edge
  task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
    load_en   = 1'b1;
    load_addr = addr;
    load_data = data;
    @(posedge clk);
    #1;
    load_en = 1'b0;
  endtask

  task automatic load_insn(inout logic [15:0] p, input opcode_t op, input logic [15:0] operand);
    load_byte(p, op);
    load_byte(p + 16'd1, operand[7:0]);
    load_byte(p + 16'd2, operand[15:8]);
    p = p + 16'd3;
  endtask

  task automatic load_program(input test_case_t tc, output logic [15:0] jmp_addr);
    logic [15:0] p;
    p = 16'h0400;
    load_byte(`CPU_RESET_LSB, 8'h00);
    load_byte(`CPU_RESET_MSB, 8'h04);
    load_byte(16'h0200, tc.a);
    load_byte(16'h0201, tc.b);
    load_byte(16'h0202, 8'h80);         // ASL source for carry set
    load_byte(16'h0300, 8'h00);
    load_insn(p, LDA_ABS, 16'h0200);
    if (tc.op == ADC_ABS && tc.cin)
      load_insn(p, ASL_ABS, 16'h0202);
    load_insn(p, tc.op, 16'h0201);
    load_insn(p, STA_ABS, 16'h0300);
    load_byte(p, NOP);
    p        = p + 16'd1;
    jmp_addr = p;
    load_insn(p, JMP_ABS, jmp_addr);    // Jump to itself
  endtask

  // ------------------------------------------------
  // One case with reset, vector, store and idle loop
  // ------------------------------------------------
  task automatic run_case(input test_case_t tc);
    logic [15:0] jmp_addr;
    logic [15:0] hits;
    int          waited;
    resetn = 1'b0;
    load_program(tc, jmp_addr);
    repeat (8) @(posedge clk);
    #1;
    resetn = 1'b1;
    assert (address == `CPU_RESET_LSB)
      else report_mismatch(tc.name, "vector lsb address", `CPU_RESET_LSB, address);
    @(posedge clk);
    #1;
    assert (address == `CPU_RESET_MSB)
      else report_mismatch(tc.name, "vector msb address", `CPU_RESET_MSB, address);
    repeat (2) @(posedge clk);
    #1;
    assert (address == 16'h0400) else report_mismatch(tc.name, "first fetch", 16'h0400, address);
    assert (status == 8'h20) else report_mismatch(tc.name, "reset status", 16'h0020, {8'h00, status});

    waited = 0;
    while (!(wr_enable && address == 16'h0300) && waited < 200) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (wr_enable && address == 16'h0300)
      else report_error(tc.name, "no store to 0300 within 200 cycles");
    assert (wr_data == tc.exp_result)
      else report_mismatch(tc.name, "stored byte", {8'h00, tc.exp_result}, {8'h00, wr_data});
    assert (status == tc.exp_status)
      else report_mismatch(tc.name, "status", {8'h00, tc.exp_status}, {8'h00, status});
    assert (mem[16'h0201] == tc.exp_mem)
      else report_mismatch(tc.name, "mem 0201", {8'h00, tc.exp_mem}, {8'h00, mem[16'h0201]});

    // NOP then JMP loop of three cycles per pass
    hits = 16'd0;
    repeat (40) begin
      @(posedge clk);
      #1;
      assert (!wr_enable) else report_error(tc.name, "memory written after the store");
      if (address == jmp_addr)
        hits = hits + 16'd1;
    end
    assert (hits >= 16'd12)
      else report_error(tc.name, $sformatf("JMP target seen only %0d times", hits));
  endtask

  initial begin
    resetn    = 1'b0;
    load_en   = 1'b0;
    load_addr = 16'h0000;
    load_data = 8'h00;

    //        name            op       a      b      cin   result status mem201
    add_case("lda_zero",      LDA_ABS, 8'h55, 8'h00, 1'b0, 8'h00, 8'h22, 8'h00);
    add_case("lda_neg",       LDA_ABS, 8'h00, 8'h80, 1'b0, 8'h80, 8'hA0, 8'h80);
    add_case("adc_plain",     ADC_ABS, 8'h12, 8'h34, 1'b0, 8'h46, 8'h20, 8'h34);
    add_case("adc_carry_in",  ADC_ABS, 8'h12, 8'h34, 1'b1, 8'h47, 8'h20, 8'h34);
    add_case("adc_overflow",  ADC_ABS, 8'h7F, 8'h01, 1'b0, 8'h80, 8'hE0, 8'h01);
    add_case("adc_carry_out", ADC_ABS, 8'hFF, 8'h01, 1'b1, 8'h01, 8'h21, 8'h01);
    add_case("and_zero",      AND_ABS, 8'hF0, 8'h0F, 1'b0, 8'h00, 8'h22, 8'h0F);
    add_case("and_neg",       AND_ABS, 8'hC3, 8'h81, 1'b0, 8'h81, 8'hA0, 8'h81);
    add_case("asl_carry",     ASL_ABS, 8'h42, 8'hC1, 1'b0, 8'h42, 8'hA1, 8'h82);
    add_case("asl_zero",      ASL_ABS, 8'h00, 8'h80, 1'b0, 8'h00, 8'h23, 8'h00);
    add_random_cases(8);

    @(posedge clk);
    #1;
    foreach (cases[i])
      run_case(cases[i]);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: cpu6502_top.f
+incdir+rtl
rtl/cpu6502_pkg.sv
rtl/cpu6502_alu.sv
rtl/cpu6502_decode.sv
rtl/cpu6502_status.sv
rtl/cpu6502_control.sv
rtl/cpu6502_top.sv
bench/cpu6502_props.sv
bench/cpu6502_tb.sv

// File: rtl/cpu6502_alu.sv
// ------------------------------------------------
// 6502 ALU
// Binary add with carry, AND, shift left, pass
// ------------------------------------------------

module cpu6502_alu (
  input  logic [7:0]            alu_a,
  input  logic [7:0]            alu_b,
  input  logic                  alu_carry_in,
  input  cpu6502_pkg::alu_op_t  alu_op,
  output logic [7:0]            alu_result,
  output logic [7:0]            alu_flags
);

  import cpu6502_pkg::*;

  logic [8:0] sum;    // Ninth bit is carry out
  logic       c_out;
  logic       v_out;

  assign sum = {1'b0, alu_a} + {1'b0, alu_b} + {8'h00, alu_carry_in};

  always_comb begin
    c_out = 1'b0;
    v_out = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        alu_result = sum[7:0];
        c_out      = sum[8];
        // Same input signs, different result sign
        v_out      = (alu_a[7] == alu_b[7]) && (sum[7] != alu_a[7]);
      end
      ALU_AND:  alu_result = alu_a & alu_b;
      ALU_SL: begin
        alu_result = {alu_a[6:0], 1'b0};
        c_out      = alu_a[7];  // Bit shifted out
      end
      default:  alu_result = alu_b;  // Load path
    endcase
  end

  // Flags in status register layout
  always_comb begin
    alu_flags             = 8'h00;
    alu_flags[FLAG_NEG]   = alu_result[7];
    alu_flags[FLAG_ZERO]  = (alu_result == 8'h00);
    alu_flags[FLAG_OVF]   = v_out;
    alu_flags[FLAG_CARRY] = c_out;
  end

endmodule

// File: rtl/cpu6502_config.svh
// ------------------------------------------------
// 6502 core constants
// Reset vector location and bus widths
// ------------------------------------------------

`ifndef CPU6502_CONFIG_SVH
`define CPU6502_CONFIG_SVH

// Reset vector, low byte then high byte
`define CPU_RESET_LSB 16'hFFFC
`define CPU_RESET_MSB 16'hFFFD

// Memory bus
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

`endif

// File: rtl/cpu6502_control.sv
// ------------------------------------------------
// 6502 controller
// Reset vector walk, fetch, decode, absolute-mode states
// ------------------------------------------------

`include "cpu6502_config.svh"

module cpu6502_control (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [`CPU_DATA_W-1:0]     rd_data,
  input  cpu6502_pkg::cpu_state_t    first_state,
  input  logic [7:0]                 alu_result,
  input  logic [7:0]                 acc,
  input  logic                       carry,
  output logic [`CPU_ADDR_W-1:0]     address,
  output logic [`CPU_DATA_W-1:0]     wr_data,
  output logic                       wr_enable,
  output cpu6502_pkg::opcode_t       ir,
  output logic [7:0]                 alu_a,
  output logic [7:0]                 alu_b,
  output logic                       alu_carry_in,
  output logic                       acc_load,
  output logic [7:0]                 acc_next,
  output logic                       commit
);

  import cpu6502_pkg::*;

  cpu_state_t              state, state_next;
  logic [`CPU_ADDR_W-1:0]  pc;     // Opcode address of current instruction
  logic [7:0]              op_lo;  // Operand LSB

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------
  always_comb begin
    case (state)
      RESET:    state_next = VECTOR_1;
      VECTOR_1: state_next = VECTOR_2;
      VECTOR_2: state_next = FETCH;
      FETCH:    state_next = DECODE;
      DECODE:   state_next = first_state;                       // From decoder
      ABS_1:    state_next = (ir == JMP_ABS) ? FETCH : ABS_2;   // JMP done in 3
      ABS_2:    state_next = (ir == ASL_ABS) ? ABS_3 : FETCH;   // ASL needs write-back
      ABS_3:    state_next = ABS_4;
      ABS_4:    state_next = FETCH;
      default:  state_next = RESET;
    endcase
  end

  // ------------------------------------------------
  // Control registers and bus
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= RESET;
      address   <= `CPU_RESET_LSB;  // Vector LSB ready on release
      wr_enable <= 1'b0;
      ir        <= NOP;
    end else begin
      state <= state_next;
      case (state)
        RESET:    address <= `CPU_RESET_MSB;
        VECTOR_1: address <= {rd_data, pc[7:0]};  // Jump straight to vector
        FETCH: begin
          ir      <= opcode_t'(rd_data);
          address <= pc + 16'd1;                  // Operand LSB
        end
        DECODE: begin
          // NOP (and anything unknown) moves on to next opcode
          address <= (first_state == FETCH) ? pc + 16'd1 : pc + 16'd2;
        end
        ABS_1: begin
          address <= {rd_data, op_lo};            // Effective address, or JMP target
          if (ir == STA_ABS)
            wr_enable <= 1'b1;                    // Store during ABS_2
        end
        ABS_2: begin
          if (ir != ASL_ABS) begin
            wr_enable <= 1'b0;
            address   <= pc + 16'd3;
          end
        end
        ABS_3: wr_enable <= 1'b1;                 // ASL write-back in ABS_4
        ABS_4: begin
          wr_enable <= 1'b0;
          address   <= pc + 16'd3;
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------
  // Program counter, operand and write data
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      RESET:    pc[7:0]  <= rd_data;
      VECTOR_1: pc[15:8] <= rd_data;
      DECODE: begin
        op_lo <= rd_data;
        if (first_state == FETCH)
          pc <= pc + 16'd1;                       // Single byte instruction
      end
      ABS_1: begin
        if (ir == JMP_ABS)
          pc <= {rd_data, op_lo};
        if (ir == STA_ABS)
          wr_data <= acc;
      end
      ABS_2: begin
        if (ir == ASL_ABS)
          wr_data <= alu_result;                  // Shifted byte for write-back
        else
          pc <= pc + 16'd3;
      end
      ABS_4: pc <= pc + 16'd3;
      default: ;
    endcase
  end

  // ALU routing, operand byte straight from memory
  assign alu_a        = (ir == ASL_ABS) ? rd_data : acc;
  assign alu_b        = rd_data;
  assign alu_carry_in = carry;

  // Result capture in ABS_2; ASL keeps A but still posts flags
  assign acc_load = (state == ABS_2) &&
                    (ir == LDA_ABS || ir == ADC_ABS || ir == AND_ABS || ir == ASL_ABS);
  assign acc_next = (ir == ASL_ABS) ? acc : alu_result;
  assign commit   = (state == FETCH);

endmodule

// File: rtl/cpu6502_decode.sv
// ------------------------------------------------
// 6502 opcode decoder
// Execute entry state, ALU op and flag mask per opcode
// ------------------------------------------------

module cpu6502_decode (
  input  cpu6502_pkg::opcode_t     ir,
  output cpu6502_pkg::cpu_state_t  first_state,
  output cpu6502_pkg::alu_op_t     alu_op,
  output logic [7:0]               flag_mask
);

  import cpu6502_pkg::*;

  always_comb begin
    // Defaults behave as NOP
    first_state = FETCH;
    alu_op      = ALU_PASS;
    flag_mask   = 8'h00;

    case (ir)
      ADC_ABS: begin
        first_state = ABS_1;
        alu_op      = ALU_ADD;
        flag_mask[FLAG_NEG]   = 1'b1;
        flag_mask[FLAG_OVF]   = 1'b1;
        flag_mask[FLAG_ZERO]  = 1'b1;
        flag_mask[FLAG_CARRY] = 1'b1;
      end
      AND_ABS, LDA_ABS: begin
        first_state = ABS_1;
        alu_op      = (ir == AND_ABS) ? ALU_AND : ALU_PASS;
        flag_mask[FLAG_NEG]  = 1'b1;
        flag_mask[FLAG_ZERO] = 1'b1;
      end
      ASL_ABS: begin
        first_state = ABS_1;
        alu_op      = ALU_SL;
        flag_mask[FLAG_NEG]   = 1'b1;
        flag_mask[FLAG_ZERO]  = 1'b1;
        flag_mask[FLAG_CARRY] = 1'b1;  // Old bit 7
      end
      JMP_ABS, STA_ABS: first_state = ABS_1;  // No flags touched
      default: ;
    endcase
  end

endmodule

// File: rtl/cpu6502_pkg.sv
// ------------------------------------------------
// 6502 core shared types
// Controller states, opcodes, ALU ops, flag bits
// ------------------------------------------------

package cpu6502_pkg;

  // ------------------------------------------------
  // Controller states
  // ------------------------------------------------
  typedef enum logic [3:0] {
    RESET,     // Reset vector LSB on the bus
    VECTOR_1,  // Reset vector MSB on the bus
    VECTOR_2,  // Vector address settles
    FETCH,     // Opcode read, results committed
    DECODE,    // Operand LSB read
    ABS_1,     // Operand MSB read
    ABS_2,     // Data read or STA write
    ABS_3,     // ASL write setup
    ABS_4      // ASL write
  } cpu_state_t;

  // Supported opcodes, absolute mode only
  typedef enum logic [7:0] {
    NOP     = 8'hEA,
    JMP_ABS = 8'h4C,
    LDA_ABS = 8'hAD,
    ADC_ABS = 8'h6D,
    AND_ABS = 8'h2D,
    ASL_ABS = 8'h0E,
    STA_ABS = 8'h8D
  } opcode_t;

  typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_SL, ALU_PASS} alu_op_t;

  // Status register bit positions
  localparam int FLAG_CARRY  = 0;
  localparam int FLAG_ZERO   = 1;
  localparam int FLAG_UNUSED = 5; // Always one
  localparam int FLAG_OVF    = 6;
  localparam int FLAG_NEG    = 7;

endpackage

// File: rtl/cpu6502_status.sv
// ------------------------------------------------
// 6502 accumulator and status register
// Results held pending until the next fetch commits them
// ------------------------------------------------

`include "cpu6502_config.svh"

module cpu6502_status (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    commit,
  input  logic                    acc_load,
  input  logic [`CPU_DATA_W-1:0]  acc_next,
  input  logic [7:0]              alu_flags,
  input  logic [7:0]              flag_mask,
  output logic [`CPU_DATA_W-1:0]  acc,
  output logic [7:0]              status,
  output logic                    carry
);

  import cpu6502_pkg::*;

  logic                    pend_valid;  // Result waiting for commit
  logic [`CPU_DATA_W-1:0]  pend_acc;
  logic [7:0]              pend_flags;
  logic [7:0]              status_merged;

  // Only masked bits change; bit 5 forced high
  always_comb begin
    status_merged              = (status & ~flag_mask) | (pend_flags & flag_mask);
    status_merged[FLAG_UNUSED] = 1'b1;
  end

  // ------------------------------------------------
  // Architectural registers
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc        <= '0;
      status     <= 8'h20;  // Only unused bit set
      pend_valid <= 1'b0;
    end else if (commit) begin
      if (pend_valid) begin
        acc    <= pend_acc;
        status <= status_merged;
      end
      pend_valid <= 1'b0;
    end else if (acc_load) begin
      pend_valid <= 1'b1;
    end
  end

  // Pending result, captured with the load strobe
  always_ff @(posedge clk) begin
    if (acc_load) begin
      pend_acc   <= acc_next;
      pend_flags <= alu_flags;
    end
  end

  assign carry = status[FLAG_CARRY];  // ADC carry in

endmodule

// File: rtl/cpu6502_top.sv
// ------------------------------------------------
// 6502 core top level
// Controller, decoder, ALU and status on one memory bus
// ------------------------------------------------

`include "cpu6502_config.svh"

module cpu6502_top (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [`CPU_DATA_W-1:0]  rd_data,
  output logic [`CPU_ADDR_W-1:0]  address,
  output logic [`CPU_DATA_W-1:0]  wr_data,
  output logic                    wr_enable,
  output logic [7:0]              status
);

  import cpu6502_pkg::*;

  // Decoder outputs
  opcode_t     ir;
  cpu_state_t  first_state;
  alu_op_t     alu_op;
  logic [7:0]  flag_mask;

  // ALU operands and results
  logic [7:0]  alu_a, alu_b, alu_result, alu_flags;
  logic        alu_carry_in;

  // Accumulator path
  logic [`CPU_DATA_W-1:0]  acc, acc_next;
  logic                    acc_load, commit, carry;

  cpu6502_control control_inst (
    .clk, .resetn, .rd_data, .first_state, .alu_result, .acc, .carry,
    .address, .wr_data, .wr_enable, .ir, .alu_a, .alu_b, .alu_carry_in,
    .acc_load, .acc_next, .commit
  );

  cpu6502_decode decode_inst (
    .ir, .first_state, .alu_op, .flag_mask
  );

  cpu6502_alu alu_inst (
    .alu_a, .alu_b, .alu_carry_in, .alu_op, .alu_result, .alu_flags
  );

  cpu6502_status status_inst (
    .clk, .resetn, .commit, .acc_load, .acc_next, .alu_flags, .flag_mask,
    .acc, .status, .carry
  );

endmodule
